//--- hdl/ppu_pkg.sv
package ppu_pkg;

  // ==================================================
  // Core types
  // ==================================================

  typedef enum logic [1:0] {
    mode_hblank   = 2'd0,
    mode_vblank   = 2'd1,
    mode_oam_scan = 2'd2,
    mode_transfer = 2'd3
  } ppu_mode_t;

  // Colour index before the palette
  typedef logic [1:0] ppu_pixel_t;

  typedef struct packed {
    logic [7:0] lcdc;
    logic [7:0] scy;
    logic [7:0] scx;
    logic [7:0] lyc;
    logic [7:0] bgp;
  } ppu_regs_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        write_en;
    logic        read_en;
  } bus_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] y;
    logic [7:0] x;
    logic [1:0] shade;
  } lcd_px_t;

  // ==================================================
  // Address map
  // ==================================================

  localparam logic [15:0] vram_start = 16'h8000;
  localparam logic [15:0] vram_end   = 16'h9FFF;
  localparam logic [15:0] oam_start  = 16'hFE00;
  localparam logic [15:0] oam_end    = 16'hFE9F;
  localparam logic [15:0] regs_start = 16'hFF40;
  localparam logic [15:0] regs_end   = 16'hFF47;

  localparam logic [15:0] reg_lcdc = 16'hFF40;
  localparam logic [15:0] reg_stat = 16'hFF41;
  localparam logic [15:0] reg_scy  = 16'hFF42;
  localparam logic [15:0] reg_scx  = 16'hFF43;
  localparam logic [15:0] reg_ly   = 16'hFF44;
  localparam logic [15:0] reg_lyc  = 16'hFF45;
  localparam logic [15:0] reg_bgp  = 16'hFF47;

  // Line timing in dots
  localparam logic [8:0] line_cycles     = 9'd456;
  localparam logic [8:0] oam_scan_cycles = 9'd80;
  localparam logic [8:0] transfer_cycles = 9'd172;

  localparam logic [7:0] screen_width = 8'd160;

endpackage

//--- hdl/ppu_timing.sv
`timescale 1ns/1ps

module ppu_timing #(
  parameter int visible_lines = 144,
  parameter int total_lines   = 154
) (
  input  logic                clk,
  input  logic                reset,
  output ppu_pkg::ppu_mode_t  mode,
  output logic [7:0]          ly,
  output logic                vblank_req
);

  localparam logic [8:0] transfer_end =
    ppu_pkg::oam_scan_cycles + ppu_pkg::transfer_cycles;

  logic [8:0] dot;
  logic       line_end;

  assign line_end = (dot == ppu_pkg::line_cycles - 9'd1);

  // ==================================================
  // Dot and line counters
  // ==================================================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      dot <= 9'd0;
      ly  <= 8'd0;
    end else begin
      if (line_end) begin
        dot <= 9'd0;
        if (ly == 8'(total_lines - 1)) begin
          ly <= 8'd0;
        end else begin
          ly <= ly + 8'd1;
        end
      end else begin
        dot <= dot + 9'd1;
      end
    end
  end

  // One-cycle pulse on the first dot of the first blank line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vblank_req <= 1'b0;
    end else begin
      vblank_req <= line_end && (ly == 8'(visible_lines - 1));
    end
  end

  // Mode follows directly from the position in the frame
  always_comb begin
    if (ly >= 8'(visible_lines)) begin
      mode = ppu_pkg::mode_vblank;
    end else if (dot < ppu_pkg::oam_scan_cycles) begin
      mode = ppu_pkg::mode_oam_scan;
    end else if (dot < transfer_end) begin
      mode = ppu_pkg::mode_transfer;
    end else begin
      mode = ppu_pkg::mode_hblank;
    end
  end

endmodule

//--- hdl/ppu_bus_regs.sv
`timescale 1ns/1ps

module ppu_bus_regs (
  input  logic                clk,
  input  logic                reset,
  input  ppu_pkg::bus_req_t   bus,
  output logic [7:0]          rdata,
  input  ppu_pkg::ppu_mode_t  mode,
  input  logic [7:0]          ly,
  output ppu_pkg::ppu_regs_t  regs,
  input  logic [12:0]         vram_addr,
  output logic [7:0]          vram_rdata
);

  logic [7:0] vram [8192];
  logic [7:0] oam  [160];

  logic in_vram;
  logic in_oam;
  logic in_regs;
  logic vram_blocked;
  logic oam_blocked;
  logic [7:0] stat;

  assign in_vram = bus.addr inside {[ppu_pkg::vram_start : ppu_pkg::vram_end]};
  assign in_oam  = bus.addr inside {[ppu_pkg::oam_start : ppu_pkg::oam_end]};
  assign in_regs = bus.addr inside {[ppu_pkg::regs_start : ppu_pkg::regs_end]};

  // Renderer owns VRAM in mode 3 and OAM in modes 2 and 3
  assign vram_blocked = (mode == ppu_pkg::mode_transfer);
  assign oam_blocked  = (mode == ppu_pkg::mode_transfer) ||
                        (mode == ppu_pkg::mode_oam_scan);

  assign stat = {1'b1, 4'b0000, (ly == regs.lyc), mode};

  // ==================================================
  // Memories
  // ==================================================
  always_ff @(posedge clk) begin
    if (bus.write_en && in_vram && !vram_blocked) begin
      vram[13'(bus.addr - ppu_pkg::vram_start)] <= bus.wdata;
    end
    if (bus.write_en && in_oam && !oam_blocked) begin
      oam[8'(bus.addr - ppu_pkg::oam_start)] <= bus.wdata;
    end
  end

  // Fetcher port is never blocked
  assign vram_rdata = vram[vram_addr];

  // ==================================================
  // Register file
  // ==================================================
  // Writes to STAT and LY are ignored
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      regs <= '0;
    end else if (bus.write_en && in_regs) begin
      case (bus.addr)
        ppu_pkg::reg_lcdc: regs.lcdc <= bus.wdata;
        ppu_pkg::reg_scy:  regs.scy  <= bus.wdata;
        ppu_pkg::reg_scx:  regs.scx  <= bus.wdata;
        ppu_pkg::reg_lyc:  regs.lyc  <= bus.wdata;
        ppu_pkg::reg_bgp:  regs.bgp  <= bus.wdata;
        default: ;
      endcase
    end
  end

  // Open bus and blocked reads return 0xFF
  always_comb begin
    rdata = 8'hFF;
    if (bus.read_en) begin
      if (in_vram) begin
        rdata = vram_blocked ? 8'hFF : vram[13'(bus.addr - ppu_pkg::vram_start)];
      end else if (in_oam) begin
        rdata = oam_blocked ? 8'hFF : oam[8'(bus.addr - ppu_pkg::oam_start)];
      end else if (in_regs) begin
        case (bus.addr)
          ppu_pkg::reg_lcdc: rdata = regs.lcdc;
          ppu_pkg::reg_stat: rdata = stat;
          ppu_pkg::reg_scy:  rdata = regs.scy;
          ppu_pkg::reg_scx:  rdata = regs.scx;
          ppu_pkg::reg_ly:   rdata = ly;
          ppu_pkg::reg_lyc:  rdata = regs.lyc;
          ppu_pkg::reg_bgp:  rdata = regs.bgp;
          default:           rdata = 8'hFF;
        endcase
      end
    end
  end

endmodule

//--- hdl/bg_fetcher.sv
`timescale 1ns/1ps

module bg_fetcher (
  input  logic                          clk,
  input  logic                          reset,
  input  ppu_pkg::ppu_mode_t            mode,
  input  logic [7:0]                    ly,
  input  ppu_pkg::ppu_regs_t            regs,
  output logic [12:0]                   vram_addr,
  input  logic [7:0]                    vram_rdata,
  input  logic [4:0]                    count,
  output logic                          push_en,
  output ppu_pkg::ppu_pixel_t [7:0]     push_row
);

  typedef enum logic [1:0] {
    st_map,
    st_lo,
    st_hi,
    st_push
  } fetch_state_t;

  fetch_state_t state;
  logic [4:0]   col;
  logic [7:0]   tile_id;
  logic [7:0]   tile_lo;
  logic [7:0]   tile_hi;
  logic [7:0]   bg_y;
  logic         active;

  assign active = (mode == ppu_pkg::mode_transfer);
  assign bg_y   = ly + regs.scy;

  // ==================================================
  // VRAM addressing
  // ==================================================
  // Map at 0x9800 or 0x9C00 and tile data from the 0x8000 base only
  always_comb begin
    case (state)
      st_map:  vram_addr = {2'b11, regs.lcdc[3], bg_y[7:3], col};
      st_lo:   vram_addr = {1'b0, tile_id, bg_y[2:0], 1'b0};
      default: vram_addr = {1'b0, tile_id, bg_y[2:0], 1'b1};
    endcase
  end

  // Push only when a full row fits
  assign push_en = active && (state == st_push) && (count <= 5'd8);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= st_map;
      col   <= 5'd0;
    end else if (!active) begin
      state <= st_map;
      col   <= regs.scx[7:3];
    end else begin
      case (state)
        st_map: state <= st_lo;
        st_lo:  state <= st_hi;
        st_hi:  state <= st_push;
        default: begin
          if (push_en) begin
            state <= st_map;
            col   <= col + 5'd1;
          end
        end
      endcase
    end
  end

  // Fetched bytes
  always_ff @(posedge clk) begin
    case (state)
      st_map:  tile_id <= vram_rdata;
      st_lo:   tile_lo <= vram_rdata;
      st_hi:   tile_hi <= vram_rdata;
      default: ;
    endcase
  end

  // Index 0 is the leftmost pixel from bit 7
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      push_row[i] = regs.lcdc[0] ? {tile_hi[7-i], tile_lo[7-i]} : 2'b00;
    end
  end

endmodule

//--- hdl/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo (
  input  logic                          clk,
  input  logic                          reset,
  input  ppu_pkg::ppu_mode_t            mode,
  input  logic                          push_en,
  input  ppu_pkg::ppu_pixel_t [7:0]     push_row,
  input  logic                          pop_en,
  output ppu_pkg::ppu_pixel_t           top_px,
  output logic [4:0]                    count
);

  ppu_pkg::ppu_pixel_t mem [16];

  logic [3:0] wr_ptr;
  logic [3:0] rd_ptr;
  logic       flush;

  assign flush  = (mode != ppu_pkg::mode_transfer);
  assign top_px = mem[rd_ptr];

  // Eight entries land in one cycle
  always_ff @(posedge clk) begin
    if (push_en) begin
      for (int i = 0; i < 8; i++) begin
        mem[wr_ptr + 4'(i)] <= push_row[i];
      end
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr <= 4'd0;
      rd_ptr <= 4'd0;
      count  <= 5'd0;
    end else if (flush) begin
      wr_ptr <= 4'd0;
      rd_ptr <= 4'd0;
      count  <= 5'd0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 4'd8;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 4'd1;
      end
      count <= count + (push_en ? 5'd8 : 5'd0) - (pop_en ? 5'd1 : 5'd0);
    end
  end

endmodule

//--- hdl/pixel_output.sv
`timescale 1ns/1ps

module pixel_output (
  input  logic                 clk,
  input  logic                 reset,
  input  ppu_pkg::ppu_mode_t   mode,
  input  logic [7:0]           ly,
  input  ppu_pkg::ppu_regs_t   regs,
  input  logic [4:0]           count,
  input  ppu_pkg::ppu_pixel_t  top_px,
  output logic                 pop_en,
  output ppu_pkg::lcd_px_t     lcd_px
);

  logic [2:0] discarded;
  logic [7:0] x_cnt;
  logic       active;
  logic       discard;

  assign active  = (mode == ppu_pkg::mode_transfer);
  assign pop_en  = active && (count != 5'd0) && (x_cnt < ppu_pkg::screen_width);
  // Fine scroll drops the first scx mod 8 pixels
  assign discard = (discarded < regs.scx[2:0]);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      discarded <= 3'd0;
      x_cnt     <= 8'd0;
      lcd_px    <= '0;
    end else begin
      lcd_px.valid <= 1'b0;
      if (!active) begin
        discarded <= 3'd0;
        x_cnt     <= 8'd0;
      end else if (pop_en) begin
        if (discard) begin
          discarded <= discarded + 3'd1;
        end else begin
          lcd_px.valid <= 1'b1;
          lcd_px.y     <= ly;
          lcd_px.x     <= x_cnt;
          lcd_px.shade <= regs.bgp[{top_px, 1'b0} +: 2];
          x_cnt        <= x_cnt + 8'd1;
        end
      end
    end
  end

endmodule

//--- hdl/ppu.sv
`timescale 1ns/1ps

module ppu #(
  parameter int visible_lines = 144,
  parameter int total_lines   = 154
) (
  input  logic               clk,
  input  logic               reset,
  input  ppu_pkg::bus_req_t  bus,
  output logic [7:0]         rdata,
  output logic               vblank_req,
  output ppu_pkg::lcd_px_t   lcd_px
);

  ppu_pkg::ppu_mode_t        mode;
  logic [7:0]                ly;
  ppu_pkg::ppu_regs_t        regs;
  logic [12:0]               vram_addr;
  logic [7:0]                vram_rdata;
  logic [4:0]                count;
  logic                      push_en;
  ppu_pkg::ppu_pixel_t [7:0] push_row;
  logic                      pop_en;
  ppu_pkg::ppu_pixel_t       top_px;

  ppu_timing #(
    .visible_lines (visible_lines),
    .total_lines   (total_lines)
  ) u_timing (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .ly         (ly),
    .vblank_req (vblank_req)
  );

  ppu_bus_regs u_bus_regs (
    .clk        (clk),
    .reset      (reset),
    .bus        (bus),
    .rdata      (rdata),
    .mode       (mode),
    .ly         (ly),
    .regs       (regs),
    .vram_addr  (vram_addr),
    .vram_rdata (vram_rdata)
  );

  // ==================================================
  // Background pipeline
  // ==================================================
  bg_fetcher u_fetcher (
    .clk        (clk),
    .reset      (reset),
    .mode       (mode),
    .ly         (ly),
    .regs       (regs),
    .vram_addr  (vram_addr),
    .vram_rdata (vram_rdata),
    .count      (count),
    .push_en    (push_en),
    .push_row   (push_row)
  );

  pixel_fifo u_fifo (
    .clk      (clk),
    .reset    (reset),
    .mode     (mode),
    .push_en  (push_en),
    .push_row (push_row),
    .pop_en   (pop_en),
    .top_px   (top_px),
    .count    (count)
  );

  pixel_output u_output (
    .clk    (clk),
    .reset  (reset),
    .mode   (mode),
    .ly     (ly),
    .regs   (regs),
    .count  (count),
    .top_px (top_px),
    .pop_en (pop_en),
    .lcd_px (lcd_px)
  );

endmodule

//--- test/ppu_sva.sv
`timescale 1ns/1ps

module ppu_sva (
  input logic               clk,
  input logic               reset,
  input logic               vblank_req,
  input ppu_pkg::ppu_mode_t mode,
  input ppu_pkg::lcd_px_t   lcd_px,
  input logic [4:0]         count
);

  // ==================================================
  // Frame timing
  // ==================================================
  // Interrupt request is a single-cycle pulse
  a_vblank_pulse: assert property (
    @(posedge clk) disable iff (reset)
    vblank_req |=> !vblank_req
  ) else $error("vblank_req high on two cycles in a row");

  // ==================================================
  // Pixel output
  // ==================================================
  a_valid_in_transfer: assert property (
    @(posedge clk) disable iff (reset)
    lcd_px.valid |-> (mode == ppu_pkg::mode_transfer)
  ) else $error("lcd_px.valid outside mode 3");

  a_x_range: assert property (
    @(posedge clk) disable iff (reset)
    lcd_px.valid |-> (lcd_px.x < ppu_pkg::screen_width)
  ) else $error("lcd_px.x beyond the screen width");

  // Fill level of the 16-entry FIFO
  a_fifo_count: assert property (
    @(posedge clk) disable iff (reset)
    count <= 5'd16
  ) else $error("pixel FIFO count above 16");

endmodule

bind ppu ppu_sva u_sva (
  .clk        (clk),
  .reset      (reset),
  .vblank_req (vblank_req),
  .mode       (mode),
  .lcd_px     (lcd_px),
  .count      (count)
);

//--- test/ppu_tb.sv
`timescale 1ns/1ps

module ppu_tb;

  localparam int visible_lines = 144;
  localparam int total_lines   = 154;

  logic              clk;
  logic              reset;
  ppu_pkg::bus_req_t bus;
  logic [7:0]        rdata;
  logic              vblank_req;
  ppu_pkg::lcd_px_t  lcd_px;

  // Reference model of VRAM and the registers the renderer uses
  logic [7:0] vram_model [8192];
  logic [7:0] m_lcdc;
  logic [7:0] m_scy;
  logic [7:0] m_scx;
  logic [7:0] m_bgp;

  int line_px [256];
  int errors = 0;
  int checks = 0;
  int cycle = 0;
  int pulse_cycle = 0;
  bit checking = 1'b0;

  ppu #(
    .visible_lines (visible_lines),
    .total_lines   (total_lines)
  ) DUT (
    .clk        (clk),
    .reset      (reset),
    .bus        (bus),
    .rdata      (rdata),
    .vblank_req (vblank_req),
    .lcd_px     (lcd_px)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("FAIL @%0t: %s", $time, msg);
    end
  endtask

  task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
    bus.addr     = a;
    bus.wdata    = d;
    bus.write_en = 1'b1;
    @(posedge clk);
    #1;
    bus.write_en = 1'b0;
  endtask

  // Read data is combinational and is sampled once the address has settled
  task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
    bus.addr    = a;
    bus.read_en = 1'b1;
    #1;
    d = rdata;
    @(posedge clk);
    #1;
    bus.read_en = 1'b0;
  endtask

  task automatic expect_read(input logic [15:0] a, input logic [7:0] exp, input string msg);
    logic [7:0] d;
    bus_read(a, d);
    check(d == exp, $sformatf("%s: read %02h, expected %02h", msg, d, exp));
  endtask

  task automatic expect_mode(input ppu_pkg::ppu_mode_t m, input string msg);
    logic [7:0] d;
    bus_read(ppu_pkg::reg_stat, d);
    check(d[1:0] == m && d[7], $sformatf("%s: STAT %02h", msg, d));
  endtask

  task automatic set_reg(input logic [15:0] a, input logic [7:0] d);
    bus_write(a, d);
    case (a)
      ppu_pkg::reg_lcdc: m_lcdc = d;
      ppu_pkg::reg_scy:  m_scy  = d;
      ppu_pkg::reg_scx:  m_scx  = d;
      ppu_pkg::reg_bgp:  m_bgp  = d;
      default: ;
    endcase
  endtask

  task automatic vram_write(input logic [12:0] a, input logic [7:0] d);
    bus_write(ppu_pkg::vram_start + 16'(a), d);
    vram_model[a] = d;
  endtask

  task automatic cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // Polls STAT until the mode shows up and returns on the following cycle
  task automatic wait_mode(input ppu_pkg::ppu_mode_t m, input int limit, input string what);
    int n;
    n = 0;
    bus.addr    = ppu_pkg::reg_stat;
    bus.read_en = 1'b1;
    #1;
    while (rdata[1:0] != m && n < limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    @(posedge clk);
    #1;
    bus.read_en = 1'b0;
    if (n >= limit) begin
      errors++;
      $display("Timeout while waiting for %s", what);
    end
  endtask

  task automatic wait_vblank(input int limit);
    int n;
    n = 0;
    while (!vblank_req && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (vblank_req) begin
      pulse_cycle = cycle;
    end else begin
      errors++;
      $display("Timeout while waiting for the vertical blank pulse");
    end
  endtask

  // ==================================================
  // Pixel reference model
  // ==================================================
  function automatic logic [1:0] expected_shade(input logic [7:0] y, input logic [7:0] x);
    logic [7:0]  by;
    logic [7:0]  bx;
    logic [7:0]  tile;
    logic [12:0] map_addr;
    logic [12:0] data_addr;
    logic [1:0]  idx;
    int          b;
    by = y + m_scy;
    bx = x + m_scx;
    map_addr = (m_lcdc[3] ? 13'h1C00 : 13'h1800) + 13'(by / 8) * 13'd32 + 13'(bx / 8);
    tile = vram_model[map_addr];
    data_addr = 13'(tile) * 13'd16 + 13'(by % 8) * 13'd2;
    b = 7 - int'(bx % 8);
    idx = {vram_model[data_addr + 13'd1][b], vram_model[data_addr][b]};
    if (!m_lcdc[0]) begin
      idx = 2'd0;
    end
    return m_bgp[int'(idx) * 2 +: 2];
  endfunction

  // Mid-cycle sampling of the registered pixel output
  always @(negedge clk) begin
    if (checking && lcd_px.valid) begin
      check(int'(lcd_px.x) == line_px[lcd_px.y],
            $sformatf("line %0d: x %0d out of order", lcd_px.y, lcd_px.x));
      check(lcd_px.shade == expected_shade(lcd_px.y, lcd_px.x),
            $sformatf("shade at (%0d,%0d) is %0d", lcd_px.x, lcd_px.y, lcd_px.shade));
      line_px[lcd_px.y]++;
    end
  end

  task automatic check_lines;
    for (int y = 0; y < 256; y++) begin
      check(line_px[y] == (y < visible_lines ? 160 : 0),
            $sformatf("line %0d carried %0d pixels", y, line_px[y]));
    end
  endtask

  // Random scroll, palette and tiles 0 to 3 over the whole selected map
  task automatic frame_setup(input bit bg_on);
    logic [12:0] map_base;
    set_reg(ppu_pkg::reg_scx, 8'($urandom));
    set_reg(ppu_pkg::reg_scy, 8'($urandom));
    set_reg(ppu_pkg::reg_bgp, 8'($urandom));
    set_reg(ppu_pkg::reg_lcdc, {3'b000, 1'b1, 1'($urandom), 2'b00, bg_on});
    map_base = m_lcdc[3] ? 13'h1C00 : 13'h1800;
    for (int i = 0; i < 64; i++) begin
      vram_write(13'(i), 8'($urandom));
    end
    for (int i = 0; i < 1024; i++) begin
      vram_write(map_base + 13'(i), 8'($urandom % 4));
    end
    foreach (line_px[i]) begin
      line_px[i] = 0;
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  initial begin
    logic [7:0] ly_now;
    int         t0;
    bus    = '0;
    reset  = 1'b1;
    m_lcdc = 8'h00;
    m_scy  = 8'h00;
    m_scx  = 8'h00;
    m_bgp  = 8'h00;
    void'($urandom(20110));
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Register file
    expect_read(ppu_pkg::reg_lcdc, 8'h00, "LCDC after reset");
    set_reg(ppu_pkg::reg_lcdc, 8'h5A);
    expect_read(ppu_pkg::reg_lcdc, 8'h5A, "LCDC readback");
    set_reg(ppu_pkg::reg_scy, 8'hC3);
    expect_read(ppu_pkg::reg_scy, 8'hC3, "SCY readback");
    set_reg(ppu_pkg::reg_scx, 8'h3C);
    expect_read(ppu_pkg::reg_scx, 8'h3C, "SCX readback");
    bus_write(ppu_pkg::reg_lyc, 8'h99);
    expect_read(ppu_pkg::reg_lyc, 8'h99, "LYC readback");
    set_reg(ppu_pkg::reg_bgp, 8'hE4);
    expect_read(ppu_pkg::reg_bgp, 8'hE4, "BGP readback");
    bus_write(ppu_pkg::reg_ly, 8'h55);
    expect_read(ppu_pkg::reg_ly, 8'h00, "LY after write");
    expect_read(16'hFF46, 8'hFF, "unmapped register");
    set_reg(ppu_pkg::reg_lcdc, 8'h00);

    // Mode sequence from dot 1 of a line
    wait_mode(ppu_pkg::mode_hblank, 1000, "hblank");
    wait_mode(ppu_pkg::mode_oam_scan, 1000, "line start");
    cycles(78);
    expect_mode(ppu_pkg::mode_oam_scan, "mode at dot 79");
    expect_mode(ppu_pkg::mode_transfer, "mode at dot 80");
    cycles(170);
    expect_mode(ppu_pkg::mode_transfer, "mode at dot 251");
    expect_mode(ppu_pkg::mode_hblank, "mode at dot 252");

    // LY=LYC flag
    bus_read(ppu_pkg::reg_ly, ly_now);
    bus_write(ppu_pkg::reg_lyc, ly_now);
    expect_read(ppu_pkg::reg_stat, 8'h84, "STAT with LY equal to LYC");
    bus_write(ppu_pkg::reg_lyc, ly_now + 8'd1);
    expect_read(ppu_pkg::reg_stat, 8'h80, "STAT with LY not equal to LYC");

    // Access blocking
    bus_write(16'h8800, 8'h3C);
    expect_read(16'h8800, 8'h3C, "VRAM readback in hblank");
    bus_write(16'hFE10, 8'hA5);
    expect_read(16'hFE10, 8'hA5, "OAM readback in hblank");
    wait_mode(ppu_pkg::mode_transfer, 1000, "mode 3");
    expect_read(16'h8800, 8'hFF, "VRAM read in mode 3");
    expect_read(16'hFE10, 8'hFF, "OAM read in mode 3");
    bus_write(16'h8800, 8'h77);
    bus_write(16'hFE10, 8'h11);
    wait_mode(ppu_pkg::mode_oam_scan, 1000, "mode 2");
    expect_read(16'hFE10, 8'hFF, "OAM read in mode 2");
    bus_write(16'hFE10, 8'h22);
    wait_mode(ppu_pkg::mode_hblank, 1000, "hblank");
    expect_read(16'h8800, 8'h3C, "VRAM after blocked write");
    expect_read(16'hFE10, 8'hA5, "OAM after blocked writes");

    // Vertical blank and a frame with the background on
    wait_vblank(80000);
    t0 = pulse_cycle;
    expect_read(ppu_pkg::reg_ly, 8'(visible_lines), "LY after vblank pulse");
    expect_mode(ppu_pkg::mode_vblank, "mode after vblank pulse");
    frame_setup(1'b1);
    checking = 1'b1;
    wait_vblank(80000);
    checking = 1'b0;
    check(pulse_cycle - t0 == total_lines * int'(ppu_pkg::line_cycles),
          $sformatf("vblank period of %0d cycles", pulse_cycle - t0));
    check_lines();

    // Background disabled
    frame_setup(1'b0);
    checking = 1'b1;
    wait_vblank(80000);
    checking = 1'b0;
    check_lines();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- sim.f
hdl/ppu_pkg.sv
hdl/ppu_timing.sv
hdl/ppu_bus_regs.sv
hdl/bg_fetcher.sv
hdl/pixel_fifo.sv
hdl/pixel_output.sv
hdl/ppu.sv
test/ppu_sva.sv
test/ppu_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module ppu_tb -Mdir obj_dir -f sim.f
	./obj_dir/Vppu_tb | tee sim.log
	@if grep -q "Simulation FAILED" sim.log; then exit 1; fi
	@grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
